/* project.f */
z80BusPkg.sv
busCycleSeq.sv
busStrobeGen.sv
refreshCounter.sv
z80BusTop.sv
tbClockGen.sv
tbZ80Bus.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tbZ80Bus
FILELIST  = project.f
BUILD_DIR = obj_dir
PASS_MSG  = Test completed successfully

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* tbZ80Bus.sv */
// Testbench for the Z80 bus-cycle engine
// Issues random bus commands with random wait states plus one command held
// off by a bus request, and checks cycle length, strobe activity, read data,
// write data and the refresh address against a reference model

`timescale 1ns/10ps

module tbZ80Bus;

    localparam int IoWait         = 1;
    localparam int ResetCycles    = 8;
    localparam int NumCmds        = 60;
    localparam int MaxWaits       = 3;
    localparam int BusRqHold      = 6;
    // Longest cycle (intAck with all waits) plus issue, start and gap clocks
    localparam int WorstCmdClocks = 4 + 2 + MaxWaits + 3;
    localparam int TimeoutCycles  =
        10 * ((NumCmds + 1) * WorstCmdClocks + ResetCycles + BusRqHold);

    logic                 CLK_n;
    logic                 Reset_s;
    logic                 cmdValid;
    z80BusPkg::CycleKind  cmdKind;
    logic [15:0]          cmdAddr;
    logic [7:0]           cmdData;
    logic                 busy;
    logic                 done;
    logic [7:0]           rdData;
    logic                 waitN;
    logic                 busRqN;
    logic                 busAkN;
    logic                 m1N;
    logic                 mreqN;
    logic                 iorqN;
    logic                 rdN;
    logic                 wrN;
    logic                 rfshN;
    logic [15:0]          addrBus;
    logic [7:0]           dataIn;
    logic [7:0]           dataOut;
    logic [5:0]           strobeN;

    // Expected values of the commands in flight, oldest first
    z80BusPkg::CycleKind  expKindQ[$];
    logic [15:0]          expAddrQ[$];
    logic [7:0]           expDataQ[$];
    logic [7:0]           expReadQ[$];
    int                   expWaitQ[$];

    logic [31:0]          rngState;
    z80BusPkg::CycleKind  drawKind;
    logic [15:0]          drawAddr;
    logic [7:0]           drawData;
    logic [7:0]           drawRead;
    int                   drawWaits;
    int                   cmdIdx;
    int                   issuedCount = 0;
    int                   doneCount = 0;
    int                   cycleCount = 0;
    int                   busyClocks;
    int                   lowCount[6];
    int                   strobeIdx;
    logic [6:0]           expRfsh;
    z80BusPkg::CycleKind  kindNow;
    int                   waitsNow;
    logic [7:0]           readNow;

    tbClockGen clkGen (
        .clk_o(CLK_n)
    );

    z80BusTop #(
        .IoWait(IoWait)
    ) dut (
        .CLK_n(CLK_n),
        .Reset_s(Reset_s),
        .cmdValid_i(cmdValid),
        .cmdKind_i(cmdKind),
        .cmdAddr_i(cmdAddr),
        .cmdData_i(cmdData),
        .busy_o(busy),
        .done_o(done),
        .rdData_o(rdData),
        .waitN_i(waitN),
        .busRqN_i(busRqN),
        .busAkN_o(busAkN),
        .m1N_o(m1N),
        .mreqN_o(mreqN),
        .iorqN_o(iorqN),
        .rdN_o(rdN),
        .wrN_o(wrN),
        .rfshN_o(rfshN),
        .addr_o(addrBus),
        .dataIn_i(dataIn),
        .dataOut_o(dataOut)
    );

    // Bit order matches the strobe index used by the reference model
    assign strobeN = {rfshN, wrN, rdN, iorqN, mreqN, m1N};

    task automatic reportFailure(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic checkEqual(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            reportFailure($sformatf("CHECK FAILED %s: got 0x%0h, expected 0x%0h",
                                    name, actual, expected));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Wait states the engine inserts by itself in T2
    function automatic int autoWaits(input z80BusPkg::CycleKind kind);
        case (kind)
            z80BusPkg::ioRead, z80BusPkg::ioWrite: return IoWait;
            z80BusPkg::intAck:                     return 2;
            default:                               return 0;
        endcase
    endfunction

    // Clocks from the first busy sample up to and including done
    function automatic int cycleLength(input z80BusPkg::CycleKind kind, input int waits);
        case (kind)
            z80BusPkg::opFetch, z80BusPkg::intAck: return 4 + autoWaits(kind) + waits;
            default:                               return 3 + autoWaits(kind) + waits;
        endcase
    endfunction

    // Rising-edge samples in which each strobe is low
    // Index 0 m1, 1 mreq, 2 iorq, 3 rd, 4 wr, 5 rfsh
    function automatic int strobeLowCount(input z80BusPkg::CycleKind kind,
                                          input int idx, input int waits);
        int t2Samples;
        int counts[6];
        t2Samples = 1 + autoWaits(kind) + waits;
        for (int i = 0; i < 6; i++) begin
            counts[i] = 0;
        end
        case (kind)
            z80BusPkg::opFetch: begin
                // MREQ drops for half a clock at T3 and returns for refresh
                counts[0] = 1 + t2Samples;
                counts[1] = 1 + t2Samples + 1;
                counts[3] = 1 + t2Samples;
                counts[5] = 2;
            end
            z80BusPkg::memRead: begin
                counts[1] = 1 + t2Samples;
                counts[3] = 1 + t2Samples;
            end
            z80BusPkg::memWrite: begin
                // WR trails MREQ by half a clock
                counts[1] = 1 + t2Samples;
                counts[4] = t2Samples;
            end
            z80BusPkg::ioRead: begin
                counts[2] = t2Samples;
                counts[3] = t2Samples;
            end
            z80BusPkg::ioWrite: begin
                counts[2] = t2Samples;
                counts[4] = t2Samples;
            end
            default: begin
                // Interrupt acknowledge keeps IORQ up to the falling edge of T4
                counts[0] = 1 + t2Samples;
                counts[2] = t2Samples + 1;
            end
        endcase
        return counts[idx];
    endfunction

    function automatic logic isReadKind(input z80BusPkg::CycleKind kind);
        return (kind != z80BusPkg::memWrite) && (kind != z80BusPkg::ioWrite);
    endfunction

    function automatic logic [6:0] nextRefresh(input logic [6:0] r);
        return 7'((int'(r) + 1) % 128);
    endfunction

    function automatic string strobeName(input int idx);
        case (idx)
            0:       return "m1N_o low samples";
            1:       return "mreqN_o low samples";
            2:       return "iorqN_o low samples";
            3:       return "rdN_o low samples";
            4:       return "wrN_o low samples";
            default: return "rfshN_o low samples";
        endcase
    endfunction

    // The first six commands walk through every kind, the rest are random
    task automatic drawCommand(input int idx);
        rngState = xorshift32(rngState);
        if (idx < 6) begin
            drawKind = z80BusPkg::CycleKind'(3'(idx));
        end else begin
            drawKind = z80BusPkg::CycleKind'(3'(rngState % 32'd6));
        end
        drawAddr = rngState[15:0];
        drawData = rngState[23:16];
        drawRead = rngState[31:24];
        rngState = xorshift32(rngState);
        drawWaits = int'(rngState[1:0]);
    endtask

    task automatic issueCommand();
        expKindQ.push_back(drawKind);
        expAddrQ.push_back(drawAddr);
        expDataQ.push_back(drawData);
        expReadQ.push_back(drawRead);
        expWaitQ.push_back(drawWaits);
        issuedCount++;
        cmdValid <= 1'b1;
        cmdKind  <= drawKind;
        cmdAddr  <= drawAddr;
        cmdData  <= drawData;
        dataIn   <= drawRead;
        @(posedge CLK_n);
        cmdValid <= 1'b0;
    endtask

    // WAIT goes low when T2 begins, so every low sample falls inside T2
    task automatic awaitCompletion(input int waits);
        while (busy !== 1'b1) begin
            @(posedge CLK_n);
        end
        if (waits > 0) begin
            waitN <= 1'b0;
            repeat (waits) @(posedge CLK_n);
            waitN <= 1'b1;
        end
        do begin
            @(posedge CLK_n);
        end while (done !== 1'b1);
    endtask

    task automatic checkResetState();
        checkEqual("strobes in reset", 32'(strobeN), 32'h3f);
        checkEqual("busAkN_o", 32'(busAkN), 32'h1);
        checkEqual("busy_o", 32'(busy), 32'h0);
        checkEqual("done_o", 32'(done), 32'h0);
    endtask

    // A command issued during a bus grant must wait for BUSRQ to rise
    task automatic busRequestTest();
        busRqN <= 1'b0;
        repeat (2) @(posedge CLK_n);
        checkEqual("busAkN_o", 32'(busAkN), 32'h0);
        drawCommand(NumCmds);
        issueCommand();
        repeat (BusRqHold) begin
            @(posedge CLK_n);
            checkEqual("busy_o", 32'(busy), 32'h0);
        end
        busRqN <= 1'b1;
        repeat (2) @(posedge CLK_n);
        checkEqual("busy_o", 32'(busy), 32'h1);
        awaitCompletion(drawWaits);
        @(posedge CLK_n);
        checkEqual("busAkN_o", 32'(busAkN), 32'h1);
    endtask

    initial begin
        Reset_s  <= 1'b0;
        cmdValid <= 1'b0;
        cmdKind  <= z80BusPkg::opFetch;
        cmdAddr  <= 16'h0000;
        cmdData  <= 8'h00;
        waitN    <= 1'b1;
        busRqN   <= 1'b1;
        dataIn   <= 8'h00;
        rngState = 32'h812af772;
        repeat (ResetCycles) @(posedge CLK_n);
        checkResetState();
        Reset_s <= 1'b1;
        repeat (2) @(posedge CLK_n);
        for (cmdIdx = 0; cmdIdx < NumCmds; cmdIdx++) begin
            drawCommand(cmdIdx);
            issueCommand();
            awaitCompletion(drawWaits);
            @(posedge CLK_n);
        end
        busRequestTest();
        repeat (4) @(posedge CLK_n);
        if (doneCount == issuedCount && expKindQ.size() == 0) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            reportFailure("Not every issued command reached done_o");
        end
    end

    // Monitor sampling the bus on each rising edge, before it updates
    always @(posedge CLK_n) begin
        if (Reset_s !== 1'b1) begin
            busyClocks = 0;
            expRfsh = 7'd0;
            for (strobeIdx = 0; strobeIdx < 6; strobeIdx++) begin
                lowCount[strobeIdx] = 0;
            end
        end else begin
            checkEqual("rdN_o|wrN_o", 32'(rdN | wrN), 32'h1);
            if (busAkN === 1'b0) begin
                checkEqual("strobes during bus grant", 32'(strobeN), 32'h3f);
                checkEqual("dataOut_o", 32'(dataOut), 32'h0);
                checkEqual("busy_o", 32'(busy), 32'h0);
            end
            if (busy === 1'b1) begin
                if (expKindQ.size() == 0) begin
                    reportFailure("busy_o went high with no command outstanding");
                end
                busyClocks = busyClocks + 1;
                for (strobeIdx = 0; strobeIdx < 6; strobeIdx++) begin
                    if (strobeN[strobeIdx] === 1'b0) begin
                        lowCount[strobeIdx] = lowCount[strobeIdx] + 1;
                    end
                end
                // The refresh half of a fetch shows R on the low address bits
                if (rfshN === 1'b0) begin
                    checkEqual("addr_o", 32'(addrBus), 32'({9'd0, expRfsh}));
                end else begin
                    checkEqual("addr_o", 32'(addrBus), 32'(expAddrQ[0]));
                end
                if (wrN === 1'b0) begin
                    checkEqual("dataOut_o", 32'(dataOut), 32'(expDataQ[0]));
                end
                if (done === 1'b1) begin
                    kindNow  = expKindQ.pop_front();
                    waitsNow = expWaitQ.pop_front();
                    readNow  = expReadQ.pop_front();
                    void'(expAddrQ.pop_front());
                    void'(expDataQ.pop_front());
                    checkEqual("cycle length", busyClocks, cycleLength(kindNow, waitsNow));
                    for (strobeIdx = 0; strobeIdx < 6; strobeIdx++) begin
                        checkEqual(strobeName(strobeIdx), lowCount[strobeIdx],
                                   strobeLowCount(kindNow, strobeIdx, waitsNow));
                        lowCount[strobeIdx] = 0;
                    end
                    if (isReadKind(kindNow)) begin
                        checkEqual("rdData_o", 32'(rdData), 32'(readNow));
                    end
                    if (kindNow == z80BusPkg::opFetch) begin
                        expRfsh = nextRefresh(expRfsh);
                    end
                    busyClocks = 0;
                    doneCount++;
                end
            end else begin
                checkEqual("strobes while idle", 32'(strobeN), 32'h3f);
                checkEqual("done_o", 32'(done), 32'h0);
            end
        end
    end

    // Watchdog on the total run length
    always @(posedge CLK_n) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TimeoutCycles) begin
            reportFailure("Timeout: the run went past its cycle limit");
        end
    end

endmodule

/* tbClockGen.sv */
// Testbench clock source
// Free-running clock with a 4 ns period that starts low at time zero

`timescale 1ns/10ps

module tbClockGen #(
    parameter int HalfPeriodNs = 2
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    // Toggle every half period for a 250 MHz bus clock
    always begin
        #(HalfPeriodNs) clk_o = ~clk_o;
    end

endmodule

/* z80BusTop.sv */
// Z80 bus-cycle engine top level
// Connects the cycle sequencer, the strobe generator and the refresh
// counter, and puts the refresh address on the bus in T3 and T4 of a fetch

`timescale 1ns/10ps

module z80BusTop #(
    parameter int IoWait = 1
) (
    input  logic                 CLK_n,
    input  logic                 Reset_s,
    input  logic                 cmdValid_i,
    input  z80BusPkg::CycleKind  cmdKind_i,
    input  logic [15:0]          cmdAddr_i,
    input  logic [7:0]           cmdData_i,
    output logic                 busy_o,
    output logic                 done_o,
    output logic [7:0]           rdData_o,
    input  logic                 waitN_i,
    input  logic                 busRqN_i,
    output logic                 busAkN_o,
    output logic                 m1N_o,
    output logic                 mreqN_o,
    output logic                 iorqN_o,
    output logic                 rdN_o,
    output logic                 wrN_o,
    output logic                 rfshN_o,
    output logic [15:0]          addr_o,
    input  logic [7:0]           dataIn_i,
    output logic [7:0]           dataOut_o
);

    z80BusPkg::CycleKind  mCycleKind;
    z80BusPkg::TState     tState;
    logic                 waitSync;
    logic                 refreshPhase;
    logic                 fetchDone;
    logic [6:0]           rfshAddr;
    logic [15:0]          seqAddr;

    busCycleSeq #(
        .IoWait(IoWait)
    ) seqInst (
        .CLK_n(CLK_n),
        .Reset_s(Reset_s),
        .cmdValid_i(cmdValid_i),
        .cmdKind_i(cmdKind_i),
        .cmdAddr_i(cmdAddr_i),
        .cmdData_i(cmdData_i),
        .waitN_i(waitN_i),
        .busRqN_i(busRqN_i),
        .busy_o(busy_o),
        .done_o(done_o),
        .mCycleKind_o(mCycleKind),
        .tState_o(tState),
        .waitSync_o(waitSync),
        .refreshPhase_o(refreshPhase),
        .fetchDone_o(fetchDone),
        .busAkN_o(busAkN_o),
        .addr_o(seqAddr),
        .dataOut_o(dataOut_o)
    );

    busStrobeGen strobeInst (
        .CLK_n(CLK_n),
        .Reset_s(Reset_s),
        .mCycleKind_i(mCycleKind),
        .tState_i(tState),
        .waitSync_i(waitSync),
        .refreshPhase_i(refreshPhase),
        .dataIn_i(dataIn_i),
        .m1N_o(m1N_o),
        .mreqN_o(mreqN_o),
        .iorqN_o(iorqN_o),
        .rdN_o(rdN_o),
        .wrN_o(wrN_o),
        .rfshN_o(rfshN_o),
        .rdData_o(rdData_o)
    );

    refreshCounter rfshInst (
        .CLK_n(CLK_n),
        .Reset_s(Reset_s),
        .fetchDone_i(fetchDone),
        .rfshAddr_o(rfshAddr)
    );

    // Refresh address goes on the low seven bits with the upper bits held at zero
    assign addr_o = refreshPhase ? {9'd0, rfshAddr} : seqAddr;

endmodule

/* refreshCounter.sv */
// Z80 refresh address counter
// Holds the low seven bits of the R register, which are put on the
// address bus during the refresh half of every opcode fetch

`timescale 1ns/10ps

module refreshCounter (
    input  logic        CLK_n,
    input  logic        Reset_s,
    input  logic        fetchDone_i,
    output logic [6:0]  rfshAddr_o
);

    logic [6:0] rfshCntQ;

    // Advances once per opcode fetch and wraps at 128
    // Bit 7 of R is outside this counter so it never changes here
    always_ff @(posedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            rfshCntQ <= 7'd0;
        end else if (fetchDone_i) begin
            rfshCntQ <= rfshCntQ + 7'd1;
        end
    end

    assign rfshAddr_o = rfshCntQ;

endmodule

/* busStrobeGen.sv */
// Z80 bus strobe generator
// Decodes cycle kind and T-state into MREQ, IORQ, RD, WR, M1 and RFSH.
// Registers on both clock edges are combined through inhibit terms so each
// strobe switches on its own half-clock edge. Read data is latched here

`timescale 1ns/10ps

module busStrobeGen (
    input  logic                 CLK_n,
    input  logic                 Reset_s,
    input  z80BusPkg::CycleKind  mCycleKind_i,
    input  z80BusPkg::TState     tState_i,
    input  logic                 waitSync_i,
    input  logic                 refreshPhase_i,
    input  logic [7:0]           dataIn_i,
    output logic                 m1N_o,
    output logic                 mreqN_o,
    output logic                 iorqN_o,
    output logic                 rdN_o,
    output logic                 wrN_o,
    output logic                 rfshN_o,
    output logic [7:0]           rdData_o
);

    z80BusPkg::TState  lastTState;
    logic              isFetch;
    logic              isMemRd;
    logic              isMemWr;
    logic              isIo;
    logic              isIoRd;
    logic              isIntAck;
    logic              isWrite;
    logic              isReadKind;
    logic              lateKind;
    logic              memReq;
    logic              memRd;
    logic              mreqInhibit;
    logic              endInhibit;
    logic              reqInhibit;
    logic              lateReq;
    logic              ioStrobe;
    logic [7:0]        rdDataQ;

    assign isFetch    = (mCycleKind_i == z80BusPkg::opFetch);
    assign isMemRd    = (mCycleKind_i == z80BusPkg::memRead);
    assign isMemWr    = (mCycleKind_i == z80BusPkg::memWrite);
    assign isIoRd     = (mCycleKind_i == z80BusPkg::ioRead);
    assign isIo       = isIoRd || (mCycleKind_i == z80BusPkg::ioWrite);
    assign isIntAck   = (mCycleKind_i == z80BusPkg::intAck);
    assign isWrite    = isMemWr || (mCycleKind_i == z80BusPkg::ioWrite);
    assign isReadKind = isFetch || isMemRd || isIoRd || isIntAck;
    // Kinds whose strobes start on the rising edge of T2
    assign lateKind   = isMemWr || isIo || isIntAck;

    always_comb begin
        if (isFetch || isIntAck) begin
            lastTState = z80BusPkg::TState'(z80BusPkg::TStatesFetch);
        end else if (isIo) begin
            lastTState = z80BusPkg::TState'(z80BusPkg::TStatesIo);
        end else begin
            lastTState = z80BusPkg::TState'(z80BusPkg::TStatesMem);
        end
    end

    // Memory request and memory read, launched on the falling edge of T1
    // An opcode fetch raises MREQ again in T3 for the refresh access
    always_ff @(negedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            memReq <= 1'b0;
            memRd  <= 1'b0;
        end else if (tState_i == 3'd1) begin
            memReq <= isFetch || isMemRd || isMemWr;
            memRd  <= isFetch || isMemRd;
        end else if (tState_i == 3'd3) begin
            memReq <= isFetch;
            memRd  <= 1'b0;
        end else if (tState_i == 3'd4) begin
            memReq <= 1'b0;
        end
    end

    // Falling-edge inhibits
    // mreqInhibit covers the half clock between the fetch read and refresh
    // endInhibit ends the late strobes on the falling edge of the last T-state
    always_ff @(negedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            mreqInhibit <= 1'b0;
            endInhibit  <= 1'b0;
        end else begin
            mreqInhibit <= isFetch && (tState_i == 3'd2);
            endInhibit  <= (tState_i == lastTState);
        end
    end

    // Rising-edge terms
    // reqInhibit cuts the fetch RD and MREQ on the rising edge of T3,
    // which only comes when the synchronised WAIT let T2 finish
    always_ff @(posedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            reqInhibit <= 1'b0;
            lateReq    <= 1'b0;
        end else begin
            reqInhibit <= isFetch && (tState_i == 3'd2) && waitSync_i;
            if (tState_i == 3'd1) begin
                lateReq <= lateKind;
            end else if (tState_i == lastTState) begin
                lateReq <= 1'b0;
            end
        end
    end

    // Read data is taken on the falling edge of the last T-state
    always_ff @(negedge CLK_n) begin
        if (isReadKind && (tState_i == lastTState)) begin
            rdDataQ <= dataIn_i;
        end
    end

    // Live from the rising edge of T2 until the falling edge of the last T-state
    assign ioStrobe = lateReq && !endInhibit;

    assign m1N_o    = !((isFetch || isIntAck) && ((tState_i == 3'd1) || (tState_i == 3'd2)));
    assign mreqN_o  = !(memReq && !(reqInhibit && mreqInhibit));
    assign iorqN_o  = !(ioStrobe && (isIo || isIntAck));
    assign rdN_o    = !((memRd && !reqInhibit) || (ioStrobe && isIoRd));
    assign wrN_o    = !(ioStrobe && isWrite);
    assign rfshN_o  = !refreshPhase_i;
    assign rdData_o = rdDataQ;

    // RD and WR come from different edge registers and must never overlap
    rdWrExclusive: assert property (@(posedge CLK_n) disable iff (!Reset_s)
        !(!rdN_o && !wrN_o))
        else $error("RD and WR strobes active together");

endmodule

/* busCycleSeq.sv */
// Z80 bus-cycle sequencer
// Takes one command at a time and steps the T-state counter of the
// machine cycle, stretching T2 for automatic and external wait states.
// Also owns the bus request / acknowledge hand-over between cycles

`timescale 1ns/10ps

module busCycleSeq #(
    parameter int IoWait = 1
) (
    input  logic                 CLK_n,
    input  logic                 Reset_s,
    input  logic                 cmdValid_i,
    input  z80BusPkg::CycleKind  cmdKind_i,
    input  logic [15:0]          cmdAddr_i,
    input  logic [7:0]           cmdData_i,
    input  logic                 waitN_i,
    input  logic                 busRqN_i,
    output logic                 busy_o,
    output logic                 done_o,
    output z80BusPkg::CycleKind  mCycleKind_o,
    output z80BusPkg::TState     tState_o,
    output logic                 waitSync_o,
    output logic                 refreshPhase_o,
    output logic                 fetchDone_o,
    output logic                 busAkN_o,
    output logic [15:0]          addr_o,
    output logic [7:0]           dataOut_o
);

    logic                 busyQ;
    logic                 pendingQ;
    logic                 busAkNQ;
    logic                 waitSyncQ;
    logic [1:0]           autoCntQ;
    logic [1:0]           autoLoad;
    logic [2:0]           waitExtra;
    logic                 lastT;
    logic                 startCycle;
    logic                 isWrite;
    logic [15:0]          addrQ;
    logic [7:0]           dataQ;
    z80BusPkg::CycleKind  kindQ;
    z80BusPkg::TState     tStateQ;
    z80BusPkg::TState     tLimit;

    // Last T-state of the cycle and the automatic waits it carries
    always_comb begin
        case (kindQ)
            z80BusPkg::opFetch,
            z80BusPkg::intAck:   tLimit = z80BusPkg::TState'(z80BusPkg::TStatesFetch);
            z80BusPkg::ioRead,
            z80BusPkg::ioWrite:  tLimit = z80BusPkg::TState'(z80BusPkg::TStatesIo);
            default:             tLimit = z80BusPkg::TState'(z80BusPkg::TStatesMem);
        endcase
        case (kindQ)
            z80BusPkg::ioRead,
            z80BusPkg::ioWrite:  autoLoad = 2'(IoWait);
            z80BusPkg::intAck:   autoLoad = 2'(z80BusPkg::IntAckAutoWaits);
            default:             autoLoad = 2'd0;
        endcase
    end

    // Each low WAIT sample adds one T-state on top of the automatic ones
    assign waitExtra  = {1'b0, autoCntQ} + {2'b00, ~waitSyncQ};
    assign lastT      = busyQ && (tStateQ == tLimit);
    // A held command starts only once the bus is ours again
    assign startCycle = !busyQ && (cmdValid_i || pendingQ) && busRqN_i;
    assign isWrite    = (kindQ == z80BusPkg::memWrite) || (kindQ == z80BusPkg::ioWrite);

    always_ff @(posedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            busyQ    <= 1'b0;
            pendingQ <= 1'b0;
            busAkNQ  <= 1'b1;
            autoCntQ <= 2'd0;
            tStateQ  <= '0;
            kindQ    <= z80BusPkg::opFetch;
        end else begin
            // BUSRQ is looked at while idle and at the last edge of a cycle
            if (!busyQ || lastT) begin
                busAkNQ <= busRqN_i;
            end
            if (!busyQ && cmdValid_i) begin
                kindQ <= cmdKind_i;
            end
            if (startCycle) begin
                pendingQ <= 1'b0;
            end else if (!busyQ && cmdValid_i) begin
                pendingQ <= 1'b1;
            end
            if (startCycle) begin
                busyQ   <= 1'b1;
                tStateQ <= 3'd1;
            end else if (busyQ) begin
                if (lastT) begin
                    busyQ   <= 1'b0;
                    tStateQ <= '0;
                end else if (tStateQ == 3'd1) begin
                    tStateQ  <= 3'd2;
                    autoCntQ <= autoLoad;
                end else if (tStateQ == 3'd2) begin
                    // Stay in T2 while any wait state is still owed
                    if (waitExtra != 3'd0) begin
                        autoCntQ <= 2'(waitExtra - 3'd1);
                    end else begin
                        tStateQ <= 3'd3;
                    end
                end else begin
                    tStateQ <= tStateQ + 3'd1;
                end
            end
        end
    end

    // Address and write data of the accepted command
    always_ff @(posedge CLK_n) begin
        if (!busyQ && cmdValid_i) begin
            addrQ <= cmdAddr_i;
            dataQ <= cmdData_i;
        end
    end

    // WAIT is synchronised on the falling edge, inside T2 and each wait state
    always_ff @(negedge CLK_n or negedge Reset_s) begin
        if (!Reset_s) begin
            waitSyncQ <= 1'b1;
        end else begin
            waitSyncQ <= waitN_i;
        end
    end

    assign busy_o         = busyQ;
    assign done_o         = lastT;
    assign mCycleKind_o   = kindQ;
    assign tState_o       = tStateQ;
    assign waitSync_o     = waitSyncQ;
    assign busAkN_o       = busAkNQ;
    assign refreshPhase_o = busyQ && (kindQ == z80BusPkg::opFetch) && (tStateQ >= 3'd3);
    assign fetchDone_o    = lastT && (kindQ == z80BusPkg::opFetch);
    assign addr_o         = busyQ ? addrQ : 16'h0000;
    // The data bus is only driven during a write and floats as zero otherwise
    assign dataOut_o      = (busyQ && isWrite) ? dataQ : 8'h00;

    // The command side must wait for busy_o to drop before the next strobe
    cmdWhileBusy: assert property (@(posedge CLK_n) disable iff (!Reset_s)
        busyQ |-> !cmdValid_i)
        else $error("command strobe while busy");

    // A running cycle always sits between T1 and the limit of its kind
    tStateLimit: assert property (@(posedge CLK_n) disable iff (!Reset_s)
        busyQ |-> ((tStateQ >= 3'd1) && (tStateQ <= tLimit)))
        else $error("T-state count ran past the cycle limit");

endmodule

/* z80BusPkg.sv */
// Z80 bus-cycle engine shared definitions
// Holds the command kind encoding and the base T-state counts of each
// machine cycle, used by the sequencer, the strobe generator and the top

package z80BusPkg;

    // Kinds of bus cycle the engine can play out
    // The encoding is carried on cmdKind_i by the command side
    typedef enum logic [2:0] {
        opFetch  = 3'd0,
        memRead  = 3'd1,
        memWrite = 3'd2,
        ioRead   = 3'd3,
        ioWrite  = 3'd4,
        intAck   = 3'd5
    } CycleKind;

    // An opcode fetch runs T1 to T4 with refresh in T3 and T4
    localparam int unsigned TStatesFetch = 4;

    // Plain memory read and write cycles end in T3
    localparam int unsigned TStatesMem = 3;

    // I/O cycles also end in T3 but get the automatic wait on top
    localparam int unsigned TStatesIo = 3;

    // Interrupt acknowledge always stretches T2 by two wait states
    // The cycle itself has the length of an opcode fetch
    localparam int unsigned IntAckAutoWaits = 2;

    // T-state number of the running machine cycle
    // Zero means idle, 1 to 4 are T1 to T4 and wait states hold the value 2
    typedef logic [2:0] TState;

endpackage
